// File: src/bladerunner_pkg.sv
// shared widths, word and address types, bus structs and cache controller states
package bladerunner_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int data_width_c      = 32;
  localparam int axil_addr_width_c = 16;
  localparam int word_addr_width_c = 14;
  localparam int block_words_c     = 4;
  localparam int sets_c            = 16;

  typedef logic [data_width_c-1:0]                          word_t;
  typedef logic [axil_addr_width_c-1:0]                     axil_addr_t;
  typedef logic [word_addr_width_c-1:0]                     word_addr_t;
  // word address with the block offset stripped
  typedef logic [word_addr_width_c-$clog2(block_words_c)-1:0] block_addr_t;

  // --------------------
  // bus structs
  // --------------------
  // host to slave
  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    word_t      wdata;
    logic       bready;
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_req_t;

  // slave to host
  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    logic [1:0] bresp;
    logic       arready;
    logic       rvalid;
    word_t      rdata;
    logic [1:0] rresp;
  } axil_rsp_t;

  typedef struct packed {
    logic       wr;
    word_addr_t addr;
    word_t      data;
  } link_req_t;

  typedef struct packed {
    logic        wr;
    block_addr_t addr;
  } dma_pkt_t;

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_evict_send,
    st_evict_data,
    st_fill_send,
    st_fill_data,
    st_respond
  } cache_state_e;

endpackage

// File: src/axil_endpoint.sv
// AXI-Lite slave endpoint that issues link requests and holds host responses
module axil_endpoint (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  bladerunner_pkg::axil_req_t axil_req_i,
  output bladerunner_pkg::axil_rsp_t axil_rsp_o,
  output bladerunner_pkg::link_req_t link_req_o,
  output logic                       link_v_o,
  input  logic                       link_ready_i,
  input  logic                       link_rsp_v_i,
  input  bladerunner_pkg::word_t     link_rsp_data_i
);
  import bladerunner_pkg::*;

  typedef enum logic [2:0] {
    ep_idle,
    ep_request,
    ep_wait,
    ep_wr_rsp,
    ep_rd_rsp
  } ep_state_e;

  ep_state_e state_q;
  logic      aw_ready_q;
  logic      ar_ready_q;
  link_req_t req_q;
  word_t     rdata_q;
  logic      wr_pending;
  logic      rd_pending;

  // byte address to word address
  function automatic word_addr_t to_word_addr(axil_addr_t byte_addr);
    return byte_addr[axil_addr_width_c-1:2];
  endfunction

  assign wr_pending = axil_req_i.awvalid && axil_req_i.wvalid;
  assign rd_pending = axil_req_i.arvalid;

  // --------------------
  // control
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q    <= ep_idle;
      aw_ready_q <= 1'b0;
      ar_ready_q <= 1'b0;
    end else begin
      // ready is a single-cycle pulse
      aw_ready_q <= 1'b0;
      ar_ready_q <= 1'b0;
      case (state_q)
        ep_idle: begin
          // writes win over reads
          if (wr_pending) begin
            aw_ready_q <= 1'b1;
            state_q    <= ep_request;
          end else if (rd_pending) begin
            ar_ready_q <= 1'b1;
            state_q    <= ep_request;
          end
        end
        ep_request: if (link_ready_i) state_q <= ep_wait;
        ep_wait: begin
          if (link_rsp_v_i) begin
            state_q <= req_q.wr ? ep_wr_rsp : ep_rd_rsp;
          end
        end
        ep_wr_rsp: if (axil_req_i.bready) state_q <= ep_idle;
        ep_rd_rsp: if (axil_req_i.rready) state_q <= ep_idle;
        default: state_q <= ep_idle;
      endcase
    end
  end

  // request and read data capture
  always_ff @(posedge clk_i) begin
    if (state_q == ep_idle) begin
      if (wr_pending) begin
        req_q.wr   <= 1'b1;
        req_q.addr <= to_word_addr(axil_req_i.awaddr);
        req_q.data <= axil_req_i.wdata;
      end else if (rd_pending) begin
        req_q.wr   <= 1'b0;
        req_q.addr <= to_word_addr(axil_req_i.araddr);
        req_q.data <= '0;
      end
    end
    if (state_q == ep_wait && link_rsp_v_i) begin
      rdata_q <= link_rsp_data_i;
    end
  end

  // --------------------
  // outputs
  // --------------------
  assign link_req_o = req_q;
  assign link_v_o   = (state_q == ep_request);

  always_comb begin
    axil_rsp_o.awready = aw_ready_q;
    axil_rsp_o.wready  = aw_ready_q;
    axil_rsp_o.bvalid  = (state_q == ep_wr_rsp);
    axil_rsp_o.bresp   = 2'b00;
    axil_rsp_o.arready = ar_ready_q;
    axil_rsp_o.rvalid  = (state_q == ep_rd_rsp);
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = 2'b00;
  end

endmodule

// File: src/vcache_blocking.sv
// blocking direct-mapped write-back cache with DMA evict and fill
module vcache_blocking #(
  parameter int sets_p        = bladerunner_pkg::sets_c,
  parameter int block_words_p = bladerunner_pkg::block_words_c
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  bladerunner_pkg::link_req_t link_req_i,
  input  logic                       link_v_i,
  output logic                       link_ready_o,
  output logic                       link_rsp_v_o,
  output bladerunner_pkg::word_t     link_rsp_data_o,
  output bladerunner_pkg::dma_pkt_t  dma_pkt_o,
  output logic                       dma_pkt_v_o,
  input  logic                       dma_pkt_yumi_i,
  input  bladerunner_pkg::word_t     dma_data_i,
  input  logic                       dma_data_v_i,
  output logic                       dma_data_ready_o,
  output bladerunner_pkg::word_t     dma_data_o,
  output logic                       dma_data_v_o,
  input  logic                       dma_data_yumi_i
);
  import bladerunner_pkg::*;

  localparam int offset_width_lp = $clog2(block_words_p);
  localparam int index_width_lp  = $clog2(sets_p);
  localparam int tag_width_lp    = word_addr_width_c - index_width_lp - offset_width_lp;
  localparam int mem_addr_width_lp = index_width_lp + offset_width_lp;

  cache_state_e state_q;
  link_req_t    req_q;
  word_t        rdata_q;
  logic [offset_width_lp-1:0] cnt_q;

  // tag, state bits and data array
  logic [tag_width_lp-1:0] tag_mem [sets_p];
  word_t                   data_mem [sets_p*block_words_p];
  logic [sets_p-1:0]       valid_q;
  logic [sets_p-1:0]       dirty_q;

  logic [tag_width_lp-1:0]      req_tag;
  logic [index_width_lp-1:0]    req_index;
  logic [offset_width_lp-1:0]   req_offset;
  logic                         hit;
  logic                         cnt_last;
  logic [mem_addr_width_lp-1:0] rd_addr;
  logic [mem_addr_width_lp-1:0] wr_addr;
  logic                         mem_we;
  word_t                        mem_wdata;
  word_t                        rd_word;

  assign {req_tag, req_index, req_offset} = req_q.addr;

  assign hit = valid_q[req_index] && (tag_mem[req_index] == req_tag);
  // block_words_p is a power of two, so the last word has an all-ones offset
  assign cnt_last = &cnt_q;

  // --------------------
  // data array access
  // --------------------
  assign rd_addr = (state_q == st_evict_data) ? {req_index, cnt_q} : {req_index, req_offset};
  assign rd_word = data_mem[rd_addr];

  always_comb begin
    mem_we    = 1'b0;
    wr_addr   = {req_index, req_offset};
    mem_wdata = req_q.data;
    if (state_q == st_lookup && hit && req_q.wr) begin
      mem_we = 1'b1;
    end else if (state_q == st_fill_data && dma_data_v_i) begin
      mem_we    = 1'b1;
      wr_addr   = {req_index, cnt_q};
      mem_wdata = dma_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_we) begin
      data_mem[wr_addr] <= mem_wdata;
    end
    // new tag once the last fill word lands
    if (state_q == st_fill_data && dma_data_v_i && cnt_last) begin
      tag_mem[req_index] <= req_tag;
    end
    if (state_q == st_idle && link_v_i) begin
      req_q <= link_req_i;
    end
    if (state_q == st_lookup && hit && !req_q.wr) begin
      rdata_q <= rd_word;
    end
  end

  // --------------------
  // controller
  // --------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= st_idle;
      valid_q <= '0;
      dirty_q <= '0;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        st_idle: if (link_v_i) state_q <= st_lookup;
        st_lookup: begin
          cnt_q <= '0;
          if (hit) begin
            if (req_q.wr) dirty_q[req_index] <= 1'b1;
            state_q <= st_respond;
          end else if (valid_q[req_index] && dirty_q[req_index]) begin
            state_q <= st_evict_send;
          end else begin
            state_q <= st_fill_send;
          end
        end
        st_evict_send: if (dma_pkt_yumi_i) state_q <= st_evict_data;
        st_evict_data: begin
          if (dma_data_yumi_i) begin
            // counter wraps back to zero for the fill
            cnt_q <= cnt_q + 1'b1;
            if (cnt_last) state_q <= st_fill_send;
          end
        end
        st_fill_send: if (dma_pkt_yumi_i) state_q <= st_fill_data;
        st_fill_data: begin
          if (dma_data_v_i) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_last) begin
              valid_q[req_index] <= 1'b1;
              dirty_q[req_index] <= 1'b0;
              // replay the access, which now hits
              state_q <= st_lookup;
            end
          end
        end
        st_respond: state_q <= st_idle;
        default: state_q <= st_idle;
      endcase
    end
  end

  // --------------------
  // outputs
  // --------------------
  assign link_ready_o    = (state_q == st_idle);
  assign link_rsp_v_o    = (state_q == st_respond);
  assign link_rsp_data_o = rdata_q;

  always_comb begin
    dma_pkt_o.wr = (state_q == st_evict_send);
    if (state_q == st_evict_send) begin
      // victim block goes back to memory
      dma_pkt_o.addr = block_addr_t'({tag_mem[req_index], req_index});
    end else begin
      dma_pkt_o.addr = block_addr_t'({req_tag, req_index});
    end
  end

  assign dma_pkt_v_o      = (state_q == st_evict_send) || (state_q == st_fill_send);
  assign dma_data_o       = rd_word;
  assign dma_data_v_o     = (state_q == st_evict_data);
  assign dma_data_ready_o = (state_q == st_fill_data);

endmodule

// File: src/bladerunner_top.sv
// top level with core reset pipeline, AXI-Lite endpoint and vcache
module bladerunner_top #(
  parameter int reset_stages_p = 4
) (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  bladerunner_pkg::axil_req_t axil_req_i,
  output bladerunner_pkg::axil_rsp_t axil_rsp_o,
  output bladerunner_pkg::dma_pkt_t  dma_pkt_o,
  output logic                       dma_pkt_v_o,
  input  logic                       dma_pkt_yumi_i,
  input  bladerunner_pkg::word_t     dma_data_i,
  input  logic                       dma_data_v_i,
  output logic                       dma_data_ready_o,
  output bladerunner_pkg::word_t     dma_data_o,
  output logic                       dma_data_v_o,
  input  logic                       dma_data_yumi_i
);
  import bladerunner_pkg::*;

  // --------------------
  // core reset pipeline
  // --------------------
  logic [reset_stages_p-1:0] rst_pipe_q;
  logic                      core_rst_n;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rst_pipe_q <= '0;
    end else begin
      rst_pipe_q <= {rst_pipe_q[reset_stages_p-2:0], 1'b1};
    end
  end

  assign core_rst_n = rst_pipe_q[reset_stages_p-1];

  // host link between endpoint and cache
  link_req_t link_req;
  logic      link_v;
  logic      link_ready;
  logic      link_rsp_v;
  word_t     link_rsp_data;

  axil_endpoint i_axil_endpoint (
    .clk_i          (clk_i),
    .rst_n_i        (core_rst_n),
    .axil_req_i     (axil_req_i),
    .axil_rsp_o     (axil_rsp_o),
    .link_req_o     (link_req),
    .link_v_o       (link_v),
    .link_ready_i   (link_ready),
    .link_rsp_v_i   (link_rsp_v),
    .link_rsp_data_i(link_rsp_data)
  );

  vcache_blocking #(
    .sets_p       (sets_c),
    .block_words_p(block_words_c)
  ) i_vcache_blocking (
    .clk_i           (clk_i),
    .rst_n_i         (core_rst_n),
    .link_req_i      (link_req),
    .link_v_i        (link_v),
    .link_ready_o    (link_ready),
    .link_rsp_v_o    (link_rsp_v),
    .link_rsp_data_o (link_rsp_data),
    .dma_pkt_o       (dma_pkt_o),
    .dma_pkt_v_o     (dma_pkt_v_o),
    .dma_pkt_yumi_i  (dma_pkt_yumi_i),
    .dma_data_i      (dma_data_i),
    .dma_data_v_i    (dma_data_v_i),
    .dma_data_ready_o(dma_data_ready_o),
    .dma_data_o      (dma_data_o),
    .dma_data_v_o    (dma_data_v_o),
    .dma_data_yumi_i (dma_data_yumi_i)
  );

endmodule

// File: tests/bladerunner_checker.sv
// handshake stability and reset assertions bound to the top level
module bladerunner_checker (
  input logic                       clk_i,
  input logic                       core_rst_n_i,
  input bladerunner_pkg::axil_req_t axil_req_i,
  input bladerunner_pkg::axil_rsp_t axil_rsp_i,
  input bladerunner_pkg::dma_pkt_t  dma_pkt_i,
  input logic                       dma_pkt_v_i,
  input logic                       dma_pkt_yumi_i,
  input logic                       dma_data_v_i,
  input logic                       dma_data_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned assert_fail_cnt = 0;

  // --------------------
  // held until accepted
  // --------------------
  b_hold_a: assert property (@(posedge clk_i) disable iff (!core_rst_n_i)
    axil_rsp_i.bvalid && !axil_req_i.bready |=>
      axil_rsp_i.bvalid && $stable(axil_rsp_i.bresp))
  else begin
    assert_fail_cnt++;
    $error("bvalid dropped or bresp changed before bready");
  end

  r_hold_a: assert property (@(posedge clk_i) disable iff (!core_rst_n_i)
    axil_rsp_i.rvalid && !axil_req_i.rready |=>
      axil_rsp_i.rvalid && $stable(axil_rsp_i.rdata))
  else begin
    assert_fail_cnt++;
    $error("rvalid dropped or rdata changed before rready");
  end

  pkt_hold_a: assert property (@(posedge clk_i) disable iff (!core_rst_n_i)
    dma_pkt_v_i && !dma_pkt_yumi_i |=> dma_pkt_v_i && $stable(dma_pkt_i))
  else begin
    assert_fail_cnt++;
    $error("dma packet dropped or changed before yumi");
  end

  // every control output low under core reset
  reset_quiet_a: assert property (@(posedge clk_i)
    !core_rst_n_i |=> !(axil_rsp_i.awready || axil_rsp_i.wready || axil_rsp_i.arready ||
      axil_rsp_i.bvalid || axil_rsp_i.rvalid || dma_pkt_v_i || dma_data_v_i ||
      dma_data_ready_i))
  else begin
    assert_fail_cnt++;
    $error("control output high while core reset is active");
  end

endmodule

bind bladerunner_top bladerunner_checker i_bladerunner_checker (
  .clk_i           (clk_i),
  .core_rst_n_i    (core_rst_n),
  .axil_req_i      (axil_req_i),
  .axil_rsp_i      (axil_rsp_o),
  .dma_pkt_i       (dma_pkt_o),
  .dma_pkt_v_i     (dma_pkt_v_o),
  .dma_pkt_yumi_i  (dma_pkt_yumi_i),
  .dma_data_v_i    (dma_data_v_o),
  .dma_data_ready_i(dma_data_ready_o)
);

// File: tests/tb_bladerunner.sv
// testbench with clock, reset, seeded host traffic, DMA memory model, reference model and report
module tb_bladerunner;
  timeunit 1ns;
  timeprecision 1ps;
  import bladerunner_pkg::*;

  localparam int    clk_period_c   = 10;
  localparam int    seed_c         = 32'h841d;
  localparam int    num_txn_c      = 400;
  localparam int    directed_txn_c = 16;
  localparam int    rand_words_c   = 256;
  localparam int    mem_words_c    = 4096;
  localparam int    off_w_c        = $clog2(block_words_c);
  localparam int    index_w_c      = $clog2(sets_c);
  localparam int    tag_w_c        = word_addr_width_c - index_w_c - off_w_c;
  localparam word_t fill_key_c     = 32'h5a5a0000;

  logic      clk_i;
  logic      rst_n_i;
  axil_req_t axil_req;
  axil_rsp_t axil_rsp;
  dma_pkt_t  dma_pkt;
  logic      dma_pkt_v;
  logic      dma_pkt_yumi;
  word_t     dma_data_in;
  logic      dma_data_in_v;
  logic      dma_data_ready;
  word_t     dma_data_out;
  logic      dma_data_out_v;
  logic      dma_data_yumi;

  word_t              dma_mem [mem_words_c];
  word_t              ref_mem [mem_words_c];
  dma_pkt_t           exp_pkt_q [$];
  logic [tag_w_c-1:0] model_tag [sets_c];
  logic               model_valid [sets_c];
  logic               model_dirty [sets_c];

  int pass_cnt;
  int fail_cnt;
  int test_fail_base;
  int ready_div;
  int evict_cnt;

  bladerunner_top i_bladerunner_top (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .axil_req_i      (axil_req),
    .axil_rsp_o      (axil_rsp),
    .dma_pkt_o       (dma_pkt),
    .dma_pkt_v_o     (dma_pkt_v),
    .dma_pkt_yumi_i  (dma_pkt_yumi),
    .dma_data_i      (dma_data_in),
    .dma_data_v_i    (dma_data_in_v),
    .dma_data_ready_o(dma_data_ready),
    .dma_data_o      (dma_data_out),
    .dma_data_v_o    (dma_data_out_v),
    .dma_data_yumi_i (dma_data_yumi)
  );

  initial begin
    clk_i = 1'b0;
    forever #(clk_period_c / 2) clk_i = ~clk_i;
  end

  // --------------------
  // compare tasks
  // --------------------
  task automatic check_word(string name, word_t actual, word_t expected);
    if (actual !== expected) begin
      fail_cnt++;
      $display("Mismatch at %0t: %s = %h, expected %h", $time, name, actual, expected);
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic check_pkt(string name, dma_pkt_t actual, dma_pkt_t expected);
    if (actual !== expected) begin
      fail_cnt++;
      $display("Mismatch at %0t: %s = %h, expected %h", $time, name, actual, expected);
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic check_resp(string name, logic [1:0] actual, logic [1:0] expected);
    if (actual !== expected) begin
      fail_cnt++;
      $display("Mismatch at %0t: %s = %b, expected %b", $time, name, actual, expected);
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic check_flag(string name, logic actual, logic expected);
    if (actual !== expected) begin
      fail_cnt++;
      $display("Mismatch at %0t: %s = %b, expected %b", $time, name, actual, expected);
    end else begin
      pass_cnt++;
    end
  endtask

  task automatic report_error(string msg);
    fail_cnt++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  task automatic check_quiet();
    check_flag("awready", axil_rsp.awready, 1'b0);
    check_flag("wready", axil_rsp.wready, 1'b0);
    check_flag("arready", axil_rsp.arready, 1'b0);
    check_flag("bvalid", axil_rsp.bvalid, 1'b0);
    check_flag("rvalid", axil_rsp.rvalid, 1'b0);
    check_flag("dma_pkt_v_o", dma_pkt_v, 1'b0);
    check_flag("dma_data_v_o", dma_data_out_v, 1'b0);
    check_flag("dma_data_ready_o", dma_data_ready, 1'b0);
  endtask

  task automatic report_test(string name);
    if (fail_cnt == test_fail_base) $display("test %s: ok", name);
    else $display("test %s: %0d failing checks", name, fail_cnt - test_fail_base);
    test_fail_base = fail_cnt;
  endtask

  // --------------------
  // reference cache model
  // --------------------
  // queues the DMA packets that one access must cause
  task automatic predict_access(logic wr, word_addr_t waddr);
    logic [index_w_c-1:0] set_idx;
    logic [tag_w_c-1:0]   tag;
    dma_pkt_t             pkt;
    set_idx = waddr[off_w_c +: index_w_c];
    tag     = waddr[word_addr_width_c-1 -: tag_w_c];
    if (model_valid[set_idx] && model_tag[set_idx] == tag) begin
      if (wr) model_dirty[set_idx] = 1'b1;
    end else begin
      if (model_valid[set_idx] && model_dirty[set_idx]) begin
        pkt.wr   = 1'b1;
        pkt.addr = {model_tag[set_idx], set_idx};
        exp_pkt_q.push_back(pkt);
      end
      pkt.wr   = 1'b0;
      pkt.addr = waddr[word_addr_width_c-1:off_w_c];
      exp_pkt_q.push_back(pkt);
      model_valid[set_idx] = 1'b1;
      model_tag[set_idx]   = tag;
      model_dirty[set_idx] = wr;
    end
  endtask

  task automatic check_pkts_done();
    if (exp_pkt_q.size() != 0) begin
      report_error("an expected DMA packet was never sent");
      exp_pkt_q.delete();
    end
  endtask

  // --------------------
  // host AXI-Lite tasks
  // --------------------
  task automatic host_write(word_addr_t waddr, word_t data);
    predict_access(1'b1, waddr);
    ref_mem[int'(waddr)] = data;
    @(negedge clk_i);
    axil_req.awvalid = 1'b1;
    axil_req.awaddr  = {waddr, 2'b00};
    axil_req.wvalid  = 1'b1;
    axil_req.wdata   = data;
    @(negedge clk_i);
    while (axil_rsp.awready !== 1'b1) @(negedge clk_i);
    check_flag("wready", axil_rsp.wready, 1'b1);
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    // random bready stalls
    while (axil_req.bready !== 1'b1) begin
      @(negedge clk_i);
      if (axil_rsp.bvalid === 1'b1) begin
        check_resp("bresp", axil_rsp.bresp, 2'b00);
        axil_req.bready = ($urandom % ready_div) == 0;
      end
    end
    @(negedge clk_i);
    axil_req.bready = 1'b0;
    check_pkts_done();
  endtask

  task automatic host_read(word_addr_t waddr);
    word_t exp;
    predict_access(1'b0, waddr);
    exp = ref_mem[int'(waddr)];
    @(negedge clk_i);
    axil_req.arvalid = 1'b1;
    axil_req.araddr  = {waddr, 2'b00};
    @(negedge clk_i);
    while (axil_rsp.arready !== 1'b1) @(negedge clk_i);
    axil_req.arvalid = 1'b0;
    // rdata must hold through every stalled cycle
    while (axil_req.rready !== 1'b1) begin
      @(negedge clk_i);
      if (axil_rsp.rvalid === 1'b1) begin
        check_word("rdata", axil_rsp.rdata, exp);
        check_resp("rresp", axil_rsp.rresp, 2'b00);
        axil_req.rready = ($urandom % ready_div) == 0;
      end
    end
    @(negedge clk_i);
    axil_req.rready = 1'b0;
    check_pkts_done();
  endtask

  // --------------------
  // DMA memory model
  // --------------------
  initial begin : dma_memory
    int       k;
    int       blk;
    int       idx;
    bit       wb_active;
    bit       fill_active;
    dma_pkt_t exp;
    dma_pkt_yumi  = 1'b0;
    dma_data_yumi = 1'b0;
    dma_data_in_v = 1'b0;
    dma_data_in   = '0;
    wb_active     = 1'b0;
    fill_active   = 1'b0;
    blk           = 0;
    idx           = 0;
    for (k = 0; k < mem_words_c; k++) dma_mem[k] = word_t'(k) ^ fill_key_c;
    forever begin
      @(negedge clk_i);
      dma_pkt_yumi  = 1'b0;
      dma_data_yumi = 1'b0;
      dma_data_in_v = 1'b0;
      if (dma_pkt_v === 1'b1 && ($urandom % 3) != 0) begin
        dma_pkt_yumi = 1'b1;
        if (exp_pkt_q.size() == 0) begin
          report_error("DMA packet sent with no access that needs it");
          exp = dma_pkt;
        end else begin
          exp = exp_pkt_q.pop_front();
          check_pkt("dma_pkt_o", dma_pkt, exp);
        end
        blk         = int'(exp.addr);
        idx         = 0;
        wb_active   = exp.wr;
        fill_active = !exp.wr;
      end else if (wb_active && dma_data_out_v === 1'b1 && ($urandom % 3) != 0) begin
        dma_data_yumi = 1'b1;
        check_word("dma_data_o", dma_data_out, ref_mem[blk*block_words_c+idx]);
        dma_mem[blk*block_words_c+idx] = dma_data_out;
        idx++;
        if (idx == block_words_c) begin
          wb_active = 1'b0;
          evict_cnt++;
        end
      end else if (fill_active && dma_data_ready === 1'b1 && ($urandom % 3) != 0) begin
        dma_data_in_v = 1'b1;
        dma_data_in   = dma_mem[blk*block_words_c+idx];
        idx++;
        if (idx == block_words_c) fill_active = 1'b0;
      end
    end
  end

  initial begin : watchdog
    #((num_txn_c + directed_txn_c) * 200 * clk_period_c);
    $display("Error: simulation timed out before all tests finished");
    $display("Test failed");
    $finish;
  end

  // --------------------
  // test sequence
  // --------------------
  initial begin : main
    int         i;
    int         evict_base;
    int         assert_fails;
    word_addr_t addr;
    void'($urandom(seed_c));
    rst_n_i   = 1'b0;
    axil_req  = '0;
    ready_div = 2;
    for (i = 0; i < mem_words_c; i++) ref_mem[i] = word_t'(i) ^ fill_key_c;
    for (i = 0; i < sets_c; i++) begin
      model_valid[i] = 1'b0;
      model_dirty[i] = 1'b0;
      model_tag[i]   = '0;
    end
    repeat (8) @(negedge clk_i);
    rst_n_i = 1'b1;

    repeat (12) begin
      @(negedge clk_i);
      check_quiet();
    end
    report_test("reset_quiet");

    host_read(14'h123);
    report_test("unwritten_read");

    host_write(14'h040, $urandom);
    host_read(14'h040);
    report_test("write_read");

    // same set as 0x010, other tag
    host_write(14'h010, $urandom);
    evict_base = evict_cnt;
    host_read(14'h050);
    if (evict_cnt != evict_base + 1) report_error("dirty block was not written back");
    report_test("dirty_evict");

    ready_div = 6;
    for (i = 0; i < 4; i++) begin
      addr = word_addr_t'(14'h080 + i * 17);
      host_write(addr, $urandom);
      host_read(addr);
    end
    ready_div = 2;
    report_test("backpressure");

    for (i = 0; i < num_txn_c; i++) begin
      addr = word_addr_t'($urandom % rand_words_c);
      if (($urandom % 2) == 1) host_write(addr, $urandom);
      else host_read(addr);
    end
    report_test("random");

    assert_fails = int'(i_bladerunner_top.i_bladerunner_checker.assert_fail_cnt);
    $display("checks passed: %0d, failed: %0d, assertion failures: %0d",
             pass_cnt, fail_cnt, assert_fails);
    if (fail_cnt == 0 && assert_fails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: project.f
src/bladerunner_pkg.sv
src/axil_endpoint.sv
src/vcache_blocking.sv
src/bladerunner_top.sv
tests/bladerunner_checker.sv
tests/tb_bladerunner.sv

// File: Makefile
TOP := tb_bladerunner
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
